/* hdl/mul_defs.svh */
`ifndef MUL_DEFS_SVH
`define MUL_DEFS_SVH

// data path widths
`define MUL_XLEN    64
`define MUL_EXT_W   66  // room for a zero-extended operand's sign
`define MUL_PROD_W  132
`define MUL_STEPS   33  // two multiplier bits per booth step

// funct3 values for the 64-bit ops
`define MUL_OP_MUL    3'd0
`define MUL_OP_MULH   3'd1
`define MUL_OP_MULHSU 3'd2
`define MUL_OP_MULHU  3'd3
// word op comes from OP-32 and gets a spare code
`define MUL_OP_MULW   3'd4

`endif

/* hdl/mul_pkg.sv */
`include "mul_defs.svh"

package mul_pkg;

	typedef logic [`MUL_XLEN-1:0]   xlen_t;
	typedef logic [`MUL_EXT_W-1:0]  ext_t;
	typedef logic [`MUL_PROD_W-1:0] prod_t;

	// wide enough for MUL_STEPS-1
	typedef logic [5:0] step_cnt_t;

	typedef enum logic [2:0] {
		OP_MUL    = `MUL_OP_MUL,
		OP_MULH   = `MUL_OP_MULH,
		OP_MULHSU = `MUL_OP_MULHSU,
		OP_MULHU  = `MUL_OP_MULHU,
		OP_MULW   = `MUL_OP_MULW
	} mul_op_t;

	typedef enum logic [1:0] {
		MS_IDLE = 2'd0,
		MS_LOAD = 2'd1,
		MS_STEP = 2'd2,
		MS_DONE = 2'd3
	} mul_state_t;

endpackage

/* hdl/mul_ctrl.sv */
`timescale 1ns/1ps

module mul_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic valid,
	input  logic last,
	output logic start,
	output logic load,
	output logic step,
	output logic done,
	output logic stall
);
	import mul_pkg::*;

	mul_state_t state;
	mul_state_t state_nxt;

	// the held request is still up in the done cycle, so it must not restart
	assign start = (state == MS_IDLE) && valid && !done;
	assign load  = (state == MS_LOAD);
	assign step  = (state == MS_STEP);
	assign stall = valid && !done;

	always_comb begin
		state_nxt = state;
		case (state)
			MS_IDLE: begin
				if (start)
					state_nxt = MS_LOAD;
			end
			MS_LOAD: begin
				state_nxt = MS_STEP;
			end
			MS_STEP: begin
				if (last)
					state_nxt = MS_DONE;  // result_sel takes the slice here
			end
			MS_DONE: begin
				state_nxt = MS_IDLE;
			end
			default: begin
				state_nxt = MS_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= MS_IDLE;
			done  <= 1'b0;
		end else begin
			state <= state_nxt;
			done  <= (state == MS_DONE);  // pulse in the cycle after MS_DONE
		end
	end

	// one done pulse per operation
	a_done_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		done |=> !done
	);

endmodule

/* hdl/mul_step_counter.sv */
`timescale 1ns/1ps
`include "mul_defs.svh"

module mul_step_counter (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic step,
	output logic last
);
	import mul_pkg::*;

	step_cnt_t count;
	logic      armed;  // an operation still owns the count

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
			armed <= 1'b0;
		end else if (start) begin
			count <= step_cnt_t'(`MUL_STEPS - 1);
			armed <= 1'b1;
		end else if (step) begin
			if (count != '0)
				count <= count - step_cnt_t'(1);
			else
				armed <= 1'b0;  // final step taken
		end
	end

	assign last = armed && (count == '0);

	// controller has to leave MS_STEP after the last step
	a_no_underflow: assert property (
		@(posedge clk) disable iff (!rst_n)
		(step && (count == '0)) |-> armed
	);

endmodule

/* hdl/booth_accum.sv */
`timescale 1ns/1ps
`include "mul_defs.svh"

module booth_accum (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             load,
	input  logic             step,
	input  mul_pkg::mul_op_t op,
	input  mul_pkg::xlen_t   src1,
	input  mul_pkg::xlen_t   src2,
	output mul_pkg::prod_t   product
);
	import mul_pkg::*;

	logic       src1_signed;
	logic       src2_signed;
	ext_t       ext1;
	ext_t       ext2;
	prod_t      mcand;   // multiplicand at product width
	ext_t       mplier;  // multiplier bits not yet recoded
	logic [2:0] trip;    // booth window for the next step
	prod_t      acc;
	prod_t      pp;

	// mulhu is unsigned on both sides and mulhsu only on src2
	always_comb begin
		src1_signed = (op != OP_MULHU);
		src2_signed = (op == OP_MUL) || (op == OP_MULH) || (op == OP_MULW);
	end

	assign ext1 = {{(`MUL_EXT_W - `MUL_XLEN){src1_signed & src1[`MUL_XLEN-1]}}, src1};
	assign ext2 = {{(`MUL_EXT_W - `MUL_XLEN){src2_signed & src2[`MUL_XLEN-1]}}, src2};

	// radix-4 recode of the window into 0, +-1, +-2 times mcand
	always_comb begin
		case (trip)
			3'b001, 3'b010: begin
				pp = mcand;
			end
			3'b011: begin
				pp = mcand << 1;
			end
			3'b100: begin
				pp = prod_t'(0) - (mcand << 1);
			end
			3'b101, 3'b110: begin
				pp = prod_t'(0) - mcand;
			end
			default: begin
				pp = '0;  // 000 and 111
			end
		endcase
	end

	// running sum with this step's partial product already in it
	assign product = acc + pp;

	always_ff @(posedge clk) begin
		if (load) begin
			mcand  <= {{(`MUL_PROD_W - `MUL_EXT_W){ext1[`MUL_EXT_W-1]}}, ext1};
			mplier <= ext2;
		end else if (step) begin
			mcand  <= mcand << 2;
			mplier <= ext_t'($signed(mplier) >>> 2);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc  <= '0;
			trip <= '0;
		end else if (load) begin
			acc  <= '0;
			trip <= {ext2[1:0], 1'b0};  // implicit zero below bit 0
		end else if (step) begin
			acc  <= product;
			trip <= mplier[3:1];  // overlaps the previous window by one bit
		end
	end

	// the step sequence starts right after the operands are captured
	a_load_then_step: assert property (
		@(posedge clk) disable iff (!rst_n)
		load |=> step
	);

endmodule

/* hdl/mul_result_sel.sv */
`timescale 1ns/1ps
`include "mul_defs.svh"

module mul_result_sel (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start,
	input  logic             last,
	input  mul_pkg::mul_op_t op,
	input  mul_pkg::prod_t   product,
	output mul_pkg::xlen_t   result
);
	import mul_pkg::*;

	localparam int HALF = `MUL_XLEN / 2;

	mul_op_t op_q;
	xlen_t   slice;

	always_ff @(posedge clk) begin
		if (start)
			op_q <= op;
	end

	always_comb begin
		case (op_q)
			OP_MUL: begin
				slice = product[`MUL_XLEN-1:0];
			end
			OP_MULW: begin
				slice = {{HALF{product[HALF-1]}}, product[HALF-1:0]};
			end
			default: begin
				slice = product[2*`MUL_XLEN-1:`MUL_XLEN];  // upper word for the mulh ops
			end
		endcase
	end

	// product already holds the final sum on the last step edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			result <= '0;
		else if (last)
			result <= slice;
	end

endmodule

/* hdl/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             valid,
	input  mul_pkg::mul_op_t op,
	input  mul_pkg::xlen_t   src1,
	input  mul_pkg::xlen_t   src2,
	output logic             stall,
	output logic             done,
	output mul_pkg::xlen_t   result
);
	import mul_pkg::*;

	logic  start;
	logic  load;
	logic  step;
	logic  last;
	prod_t product;

	mul_ctrl ctrl0 (
		.clk   (clk),
		.rst_n (rst_n),
		.valid (valid),
		.last  (last),
		.start (start),
		.load  (load),
		.step  (step),
		.done  (done),
		.stall (stall)
	);

	mul_step_counter cnt0 (
		.clk   (clk),
		.rst_n (rst_n),
		.start (start),
		.step  (step),
		.last  (last)
	);

	booth_accum accum0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.load    (load),
		.step    (step),
		.op      (op),
		.src1    (src1),
		.src2    (src2),
		.product (product)
	);

	mul_result_sel res0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.last    (last),
		.op      (op),
		.product (product),
		.result  (result)
	);

endmodule

/* sim/tb_mul_unit.sv */
`timescale 1ns/1ps
`include "mul_defs.svh"

module tb_mul_unit;
	import mul_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RST_CYCLES = 10;
	localparam int LATENCY    = `MUL_STEPS + 2;  // load, steps, done state
	localparam int N_CORNER   = 5 * 5 * 5;
	localparam int N_RANDOM   = 200;
	localparam int N_TIMING   = 5;
	localparam int N_B2B      = 8;
	localparam int N_OPS      = N_CORNER + N_RANDOM + N_TIMING + N_B2B + 1;
	localparam int WATCHDOG_CYCLES = N_OPS * 40 + RST_CYCLES + 500;

	logic    clk;
	logic    rst_n;
	logic    valid;
	mul_op_t op;
	xlen_t   src1;
	xlen_t   src2;
	logic    stall;
	logic    done;
	xlen_t   result;

	logic [31:0] lfsr;
	xlen_t       last_expected;

	mul_unit dut0 (
		.clk    (clk),
		.rst_n  (rst_n),
		.valid  (valid),
		.op     (op),
		.src1   (src1),
		.src2   (src2),
		.stall  (stall),
		.done   (done),
		.result (result)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		report_failure("timeout, the tests did not finish in the expected time");
	end

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		$display("** Error at time %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
		abort_run();
	endtask

	task automatic report_failure(input string msg);
		$display("Failure at time %0t: %s", $time, msg);
		abort_run();
	endtask

	// 32-bit galois with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_word(output xlen_t w);
		int k;
		w = '0;
		for (k = 0; k < `MUL_XLEN; k++) begin
			lfsr = lfsr_step(lfsr);
			w = {w[`MUL_XLEN-2:0], lfsr[0]};  // one step per bit
		end
	endtask

	function automatic mul_op_t op_from_index(input int k);
		case (k % 5)
			0: op_from_index = OP_MUL;
			1: op_from_index = OP_MULH;
			2: op_from_index = OP_MULHSU;
			3: op_from_index = OP_MULHU;
			default: op_from_index = OP_MULW;
		endcase
	endfunction

	// reference from the rv64m definitions on the full 128-bit product
	function automatic xlen_t ref_result(input mul_op_t o, input xlen_t a, input xlen_t b);
		logic         a_signed;
		logic         b_signed;
		logic [127:0] a_wide;
		logic [127:0] b_wide;
		logic [127:0] full;
		case (o)
			OP_MULHSU: begin
				a_signed = 1'b1;
				b_signed = 1'b0;
			end
			OP_MULHU: begin
				a_signed = 1'b0;
				b_signed = 1'b0;
			end
			default: begin
				a_signed = 1'b1;
				b_signed = 1'b1;
			end
		endcase
		a_wide = a_signed ? {{64{a[63]}}, a} : {64'd0, a};
		b_wide = b_signed ? {{64{b[63]}}, b} : {64'd0, b};
		full = a_wide * b_wide;
		case (o)
			OP_MUL:  ref_result = full[63:0];
			OP_MULW: ref_result = {{32{full[31]}}, full[31:0]};  // word op
			default: ref_result = full[127:64];
		endcase
	endfunction

	// returns at the falling edge inside the done cycle
	task automatic wait_done();
		int waited;
		waited = 0;
		@(negedge clk);
		while (done !== 1'b1) begin
			if (waited > LATENCY + 8)
				report_failure("done never came after an operation was issued");
			waited++;
			@(negedge clk);
		end
	endtask

	task automatic run_op(input mul_op_t o, input xlen_t a, input xlen_t b);
		xlen_t exp;
		exp = ref_result(o, a, b);
		last_expected = exp;
		@(posedge clk);
		valid <= 1'b1;
		op    <= o;
		src1  <= a;
		src2  <= b;
		wait_done();
		assert (result === exp) else report_mismatch("result", exp, result);
	endtask

	task automatic release_bus();
		@(posedge clk);
		valid <= 1'b0;
	endtask

	task automatic expect_reset_values();
		@(negedge clk);
		assert (stall === 1'b0) else report_mismatch("stall", 0, stall);
		assert (done === 1'b0) else report_mismatch("done", 0, done);
		assert (result === '0) else report_mismatch("result", 0, result);
	endtask

	task automatic sweep_corners();
		xlen_t corner [5];
		int    o;
		int    i;
		int    j;
		corner[0] = '0;
		corner[1] = 64'd1;
		corner[2] = '1;
		corner[3] = {1'b1, 63'd0};  // most negative
		corner[4] = {1'b0, {63{1'b1}}};
		for (o = 0; o < 5; o++)
			for (i = 0; i < 5; i++)
				for (j = 0; j < 5; j++)
					run_op(op_from_index(o), corner[i], corner[j]);
		release_bus();
	endtask

	task automatic random_pairs();
		xlen_t a;
		xlen_t b;
		int    i;
		for (i = 0; i < N_RANDOM; i++) begin
			rand_word(a);
			rand_word(b);
			run_op(op_from_index(i), a, b);
		end
		release_bus();
	endtask

	task automatic measure_timing();
		xlen_t a;
		xlen_t b;
		xlen_t exp;
		int    i;
		int    offset;
		for (i = 0; i < N_TIMING; i++) begin
			rand_word(a);
			rand_word(b);
			exp = ref_result(op_from_index(i), a, b);
			@(posedge clk);
			valid <= 1'b1;
			op    <= op_from_index(i);
			src1  <= a;
			src2  <= b;
			@(negedge clk);  // before the accepting edge
			assert (stall === 1'b1) else report_mismatch("stall", 1, stall);
			offset = 0;
			@(negedge clk);
			while (done !== 1'b1) begin
				assert (stall === 1'b1) else report_mismatch("stall", 1, stall);
				if (offset > LATENCY + 8)
					report_failure("done never came in the timing test");
				offset++;
				@(negedge clk);
			end
			assert (offset == LATENCY) else report_mismatch("done latency", LATENCY, offset);
			assert (stall === 1'b0) else report_mismatch("stall", 0, stall);
			assert (result === exp) else report_mismatch("result", exp, result);
			release_bus();
			@(negedge clk);
			assert (done === 1'b0) else report_mismatch("done", 0, done);
		end
	endtask

	task automatic back_to_back_ops();
		xlen_t a;
		xlen_t b;
		int    i;
		for (i = 0; i < N_B2B; i++) begin
			rand_word(a);
			rand_word(b);
			run_op(op_from_index(i + 2), a, b);  // next op in the cycle after done
		end
		release_bus();
		repeat (6) begin
			@(negedge clk);
			assert (result === last_expected) else report_mismatch("result", last_expected, result);
			assert (done === 1'b0) else report_mismatch("done", 0, done);
			assert (stall === 1'b0) else report_mismatch("stall", 0, stall);
		end
		rand_word(a);
		rand_word(b);
		run_op(OP_MULHSU, a, b);
		release_bus();
	endtask

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
		valid = 1'b0;
		op    = OP_MUL;
		src1  = '0;
		src2  = '0;
		lfsr  = 32'd65745;
		last_expected = '0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		expect_reset_values();
		sweep_corners();
		random_pairs();
		measure_timing();
		back_to_back_ops();
		$display("TB PASSED");
		$finish;
	end

endmodule

/* sources.f */
+incdir+hdl
hdl/mul_pkg.sv
hdl/mul_ctrl.sv
hdl/mul_step_counter.sv
hdl/booth_accum.sv
hdl/mul_result_sel.sv
hdl/mul_unit.sv
sim/tb_mul_unit.sv

/* Bender.yml */
package:
  name: mul_unit

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mul_pkg.sv
      - hdl/mul_ctrl.sv
      - hdl/mul_step_counter.sv
      - hdl/booth_accum.sv
      - hdl/mul_result_sel.sv
      - hdl/mul_unit.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/tb_mul_unit.sv
